// ==== src/ao_periph_pkg.sv ====
/* Always-on peripheral subsystem definitions
   Bus widths, slot map, register offsets and byte strobe merge */
`default_nettype none

package ao_periph_pkg;

  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;

  localparam int unsigned NUM_SLOTS       = 4;
  localparam int unsigned SLOT_SEL_WIDTH  = 2;
  localparam int unsigned SLOT_OFFSET_LSB = 12;

  localparam int unsigned SOC_CTRL_IDX   = 0;
  localparam int unsigned TIMER_IDX      = 1;
  localparam int unsigned FAST_INTR_IDX  = 2;
  localparam int unsigned EXT_PERIPH_IDX = 3;

  // 16 KiB window, four 4 KiB slots
  localparam logic [ADDR_WIDTH-1:0] AO_BASE_DEFAULT = 32'h2000_0000;
  localparam int unsigned NUM_FAST_INTR_DEFAULT = 15;

  localparam logic [SLOT_OFFSET_LSB-1:0] SOC_EXIT_VALID_OFS = 12'h000;
  localparam logic [SLOT_OFFSET_LSB-1:0] SOC_EXIT_VALUE_OFS = 12'h004;
  localparam logic [SLOT_OFFSET_LSB-1:0] SOC_BOOT_SEL_OFS   = 12'h008;

  localparam logic [SLOT_OFFSET_LSB-1:0] TMR_PRESCALE_OFS = 12'h000;
  localparam logic [SLOT_OFFSET_LSB-1:0] TMR_CTRL_OFS     = 12'h004;
  localparam logic [SLOT_OFFSET_LSB-1:0] TMR_MTIME_OFS    = 12'h008;
  localparam logic [SLOT_OFFSET_LSB-1:0] TMR_CMP0_OFS     = 12'h010;
  localparam logic [SLOT_OFFSET_LSB-1:0] TMR_CMP1_OFS     = 12'h014;
  localparam logic [SLOT_OFFSET_LSB-1:0] TMR_INTR_OFS     = 12'h018;

  localparam logic [SLOT_OFFSET_LSB-1:0] FIC_PENDING_OFS = 12'h000;
  localparam logic [SLOT_OFFSET_LSB-1:0] FIC_ENABLE_OFS  = 12'h004;

  // Replace the strobed bytes of a register word
  function automatic logic [DATA_WIDTH-1:0] apply_strb(input logic [DATA_WIDTH-1:0] old_val,
                                                       input logic [DATA_WIDTH-1:0] wdata,
                                                       input logic [STRB_WIDTH-1:0] strb);
    logic [DATA_WIDTH-1:0] res;
    res = old_val;
    for (int b = 0; b < STRB_WIDTH; b++) begin
      if (strb[b]) res[8*b +: 8] = wdata[8*b +: 8];
    end
    return res;
  endfunction

endpackage

`default_nettype wire

// ==== src/periph_to_reg.sv ====
/* Core memory port to register bus bridge
   Holds one request on the register bus until the slave answers */
`default_nettype none

module periph_to_reg (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                req_i,
  input  logic                                we_i,
  input  logic [ao_periph_pkg::ADDR_WIDTH-1:0] addr_i,
  input  logic [ao_periph_pkg::DATA_WIDTH-1:0] wdata_i,
  input  logic [ao_periph_pkg::STRB_WIDTH-1:0] be_i,
  output logic                                gnt_o,
  output logic                                rvalid_o,
  output logic [ao_periph_pkg::DATA_WIDTH-1:0] rdata_o,
  output logic                                err_o,
  output logic                                reg_valid_o,
  output logic                                reg_write_o,
  output logic [ao_periph_pkg::ADDR_WIDTH-1:0] reg_addr_o,
  output logic [ao_periph_pkg::DATA_WIDTH-1:0] reg_wdata_o,
  output logic [ao_periph_pkg::STRB_WIDTH-1:0] reg_wstrb_o,
  input  logic                                reg_ready_i,
  input  logic [ao_periph_pkg::DATA_WIDTH-1:0] reg_rdata_i,
  input  logic                                reg_error_i
);
  import ao_periph_pkg::*;

  logic                  busy_q;
  logic                  write_q;
  logic [ADDR_WIDTH-1:0] addr_q;
  logic [DATA_WIDTH-1:0] wdata_q;
  logic [STRB_WIDTH-1:0] wstrb_q;
  logic                  rvalid_q;
  logic [DATA_WIDTH-1:0] rdata_q;
  logic                  err_q;
  logic                  accept;
  logic                  done;

  assign gnt_o  = ~busy_q;
  assign accept = req_i & gnt_o;
  assign done   = busy_q & reg_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q   <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (accept) begin
        busy_q <= 1'b1;
      end else if (done) begin
        busy_q <= 1'b0;
      end
      rvalid_q <= done;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      write_q <= we_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
      wstrb_q <= be_i;
    end
    // Writes return zero data
    if (done) begin
      rdata_q <= write_q ? '0 : reg_rdata_i;
      err_q   <= reg_error_i;
    end
  end

  assign reg_valid_o = busy_q;
  assign reg_write_o = write_q;
  assign reg_addr_o  = addr_q;
  assign reg_wdata_o = wdata_q;
  assign reg_wstrb_o = wstrb_q;

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign err_o    = err_q;

  // Request stays put while the slave stalls
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    reg_valid_o && !reg_ready_i |=> reg_valid_o &&
      $stable({reg_write_o, reg_addr_o, reg_wdata_o, reg_wstrb_o}));

endmodule

`default_nettype wire

// ==== src/reg_demux.sv ====
/* Register bus demultiplexer
   Decodes the window, steers valid to one slot and returns its response */
`default_nettype none

module reg_demux #(
  parameter logic [ao_periph_pkg::ADDR_WIDTH-1:0] AO_BASE_ADDR = ao_periph_pkg::AO_BASE_DEFAULT
) (
  input  logic                                                         reg_valid_i,
  input  logic [ao_periph_pkg::ADDR_WIDTH-1:0]                         reg_addr_i,
  output logic                                                         reg_ready_o,
  output logic [ao_periph_pkg::DATA_WIDTH-1:0]                         reg_rdata_o,
  output logic                                                         reg_error_o,
  output logic [ao_periph_pkg::NUM_SLOTS-1:0]                          slot_valid_o,
  input  logic [ao_periph_pkg::NUM_SLOTS-1:0]                          slot_ready_i,
  input  logic [ao_periph_pkg::NUM_SLOTS-1:0][ao_periph_pkg::DATA_WIDTH-1:0] slot_rdata_i,
  input  logic [ao_periph_pkg::NUM_SLOTS-1:0]                          slot_error_i
);
  import ao_periph_pkg::*;

  // Lowest address bit above the slot index
  localparam int unsigned WIN_LSB = SLOT_OFFSET_LSB + SLOT_SEL_WIDTH;

  logic                      in_window;
  logic [SLOT_SEL_WIDTH-1:0] slot_sel;

  assign in_window = reg_addr_i[ADDR_WIDTH-1:WIN_LSB] == AO_BASE_ADDR[ADDR_WIDTH-1:WIN_LSB];
  assign slot_sel  = reg_addr_i[SLOT_OFFSET_LSB +: SLOT_SEL_WIDTH];

  always_comb begin
    // Outside the window the access ends at once with an error
    slot_valid_o = '0;
    reg_ready_o  = 1'b1;
    reg_rdata_o  = '0;
    reg_error_o  = 1'b1;
    if (in_window) begin
      slot_valid_o[slot_sel] = reg_valid_i;
      reg_ready_o = slot_ready_i[slot_sel];
      reg_rdata_o = slot_rdata_i[slot_sel];
      reg_error_o = slot_error_i[slot_sel];
    end
  end

  always_comb begin
    a_one_slot: assert ($onehot0(slot_valid_o));
  end

endmodule

`default_nettype wire

// ==== src/soc_ctrl.sv ====
/* SoC control registers
   Exit status for the test harness and synchronized boot-select readback */
`default_nettype none

module soc_ctrl (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                reg_valid_i,
  input  logic                                reg_write_i,
  input  logic [ao_periph_pkg::ADDR_WIDTH-1:0] reg_addr_i,
  input  logic [ao_periph_pkg::DATA_WIDTH-1:0] reg_wdata_i,
  input  logic [ao_periph_pkg::STRB_WIDTH-1:0] reg_wstrb_i,
  output logic                                reg_ready_o,
  output logic [ao_periph_pkg::DATA_WIDTH-1:0] reg_rdata_o,
  output logic                                reg_error_o,
  input  logic                                boot_select_i,
  output logic                                exit_valid_o,
  output logic [ao_periph_pkg::DATA_WIDTH-1:0] exit_value_o
);
  import ao_periph_pkg::*;

  logic [SLOT_OFFSET_LSB-1:0] ofs;
  logic                       wr_en;
  logic                       exit_valid_q;
  logic [DATA_WIDTH-1:0]      exit_value_q;
  logic [1:0]                 boot_sync_q;

  assign ofs         = reg_addr_i[SLOT_OFFSET_LSB-1:0];
  assign wr_en       = reg_valid_i & reg_write_i;
  assign reg_ready_o = reg_valid_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
      boot_sync_q  <= '0;
    end else begin
      boot_sync_q <= {boot_sync_q[0], boot_select_i};
      if (wr_en && ofs == SOC_EXIT_VALID_OFS && reg_wstrb_i[0]) begin
        exit_valid_q <= reg_wdata_i[0];
      end
      if (wr_en && ofs == SOC_EXIT_VALUE_OFS) begin
        exit_value_q <= apply_strb(exit_value_q, reg_wdata_i, reg_wstrb_i);
      end
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    reg_error_o = 1'b0;
    case (ofs)
      SOC_EXIT_VALID_OFS: reg_rdata_o = DATA_WIDTH'(exit_valid_q);
      SOC_EXIT_VALUE_OFS: reg_rdata_o = exit_value_q;
      SOC_BOOT_SEL_OFS:   reg_rdata_o = DATA_WIDTH'(boot_sync_q[1]);
      default:            reg_error_o = 1'b1;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

`default_nettype wire

// ==== src/ao_timer.sv ====
/* Always-on machine timer
   Prescaled 32-bit mtime with two compare channels and sticky interrupts */
`default_nettype none

module ao_timer (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                reg_valid_i,
  input  logic                                reg_write_i,
  input  logic [ao_periph_pkg::ADDR_WIDTH-1:0] reg_addr_i,
  input  logic [ao_periph_pkg::DATA_WIDTH-1:0] reg_wdata_i,
  input  logic [ao_periph_pkg::STRB_WIDTH-1:0] reg_wstrb_i,
  output logic                                reg_ready_o,
  output logic [ao_periph_pkg::DATA_WIDTH-1:0] reg_rdata_o,
  output logic                                reg_error_o,
  output logic                                timer_0_intr_o,
  output logic                                timer_1_intr_o
);
  import ao_periph_pkg::*;

  logic [SLOT_OFFSET_LSB-1:0] ofs;
  logic                       wr_en;
  logic [DATA_WIDTH-1:0]      prescale_q;
  logic [DATA_WIDTH-1:0]      presc_cnt_q;
  logic [2:0]                 ctrl_q;
  logic [DATA_WIDTH-1:0]      mtime_q;
  logic [DATA_WIDTH-1:0]      cmp0_q;
  logic [DATA_WIDTH-1:0]      cmp1_q;
  logic [1:0]                 intr_q;
  logic                       tick;
  logic [1:0]                 hit;
  logic [1:0]                 intr_clr;

  assign ofs         = reg_addr_i[SLOT_OFFSET_LSB-1:0];
  assign wr_en       = reg_valid_i & reg_write_i;
  assign reg_ready_o = reg_valid_i;

  // CTRL bit 0 runs the counter, bits 1 and 2 enable the channels
  assign tick     = ctrl_q[0] & (presc_cnt_q == prescale_q);
  assign hit[0]   = ctrl_q[1] & (mtime_q >= cmp0_q);
  assign hit[1]   = ctrl_q[2] & (mtime_q >= cmp1_q);
  assign intr_clr = (wr_en && ofs == TMR_INTR_OFS && reg_wstrb_i[0]) ? reg_wdata_i[1:0] : 2'b00;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      prescale_q  <= '0;
      presc_cnt_q <= '0;
      ctrl_q      <= '0;
      mtime_q     <= '0;
      cmp0_q      <= '0;
      cmp1_q      <= '0;
      intr_q      <= '0;
    end else begin
      if (wr_en && ofs == TMR_PRESCALE_OFS) begin
        prescale_q  <= apply_strb(prescale_q, reg_wdata_i, reg_wstrb_i);
        presc_cnt_q <= '0;
      end else if (tick) begin
        presc_cnt_q <= '0;
      end else if (ctrl_q[0]) begin
        presc_cnt_q <= presc_cnt_q + 1'b1;
      end
      // Software write to mtime beats the tick
      if (wr_en && ofs == TMR_MTIME_OFS) begin
        mtime_q <= apply_strb(mtime_q, reg_wdata_i, reg_wstrb_i);
      end else if (tick) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (wr_en && ofs == TMR_CTRL_OFS && reg_wstrb_i[0]) ctrl_q <= reg_wdata_i[2:0];
      if (wr_en && ofs == TMR_CMP0_OFS) cmp0_q <= apply_strb(cmp0_q, reg_wdata_i, reg_wstrb_i);
      if (wr_en && ofs == TMR_CMP1_OFS) cmp1_q <= apply_strb(cmp1_q, reg_wdata_i, reg_wstrb_i);
      intr_q <= (intr_q & ~intr_clr) | hit;
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    reg_error_o = 1'b0;
    case (ofs)
      TMR_PRESCALE_OFS: reg_rdata_o = prescale_q;
      TMR_CTRL_OFS:     reg_rdata_o = DATA_WIDTH'(ctrl_q);
      TMR_MTIME_OFS:    reg_rdata_o = mtime_q;
      TMR_CMP0_OFS:     reg_rdata_o = cmp0_q;
      TMR_CMP1_OFS:     reg_rdata_o = cmp1_q;
      TMR_INTR_OFS:     reg_rdata_o = DATA_WIDTH'(intr_q);
      default:          reg_error_o = 1'b1;
    endcase
  end

  assign timer_0_intr_o = intr_q[0];
  assign timer_1_intr_o = intr_q[1];

  a_presc_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    presc_cnt_q <= prescale_q);

endmodule

`default_nettype wire

// ==== src/fast_intr_ctrl.sv ====
/* Fast interrupt controller
   Sticky pending bits per line, masked by an enable register */
`default_nettype none

module fast_intr_ctrl #(
  parameter int unsigned NUM_FAST_INTR = ao_periph_pkg::NUM_FAST_INTR_DEFAULT
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                reg_valid_i,
  input  logic                                reg_write_i,
  input  logic [ao_periph_pkg::ADDR_WIDTH-1:0] reg_addr_i,
  input  logic [ao_periph_pkg::DATA_WIDTH-1:0] reg_wdata_i,
  input  logic [ao_periph_pkg::STRB_WIDTH-1:0] reg_wstrb_i,
  output logic                                reg_ready_o,
  output logic [ao_periph_pkg::DATA_WIDTH-1:0] reg_rdata_o,
  output logic                                reg_error_o,
  input  logic [NUM_FAST_INTR-1:0]            fast_intr_i,
  output logic [NUM_FAST_INTR-1:0]            fast_intr_o
);
  import ao_periph_pkg::*;

  logic [SLOT_OFFSET_LSB-1:0] ofs;
  logic                       wr_en;
  logic [NUM_FAST_INTR-1:0]   wmask;
  logic [NUM_FAST_INTR-1:0]   pending_q;
  logic [NUM_FAST_INTR-1:0]   enable_q;
  logic [NUM_FAST_INTR-1:0]   pend_clr;

  assign ofs         = reg_addr_i[SLOT_OFFSET_LSB-1:0];
  assign wr_en       = reg_valid_i & reg_write_i;
  assign reg_ready_o = reg_valid_i;
  assign wmask       = NUM_FAST_INTR'(apply_strb('0, reg_wdata_i, reg_wstrb_i));
  assign pend_clr    = (wr_en && ofs == FIC_PENDING_OFS) ? wmask : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      // A line still asserted keeps its bit set
      pending_q <= (pending_q & ~pend_clr) | fast_intr_i;
      if (wr_en && ofs == FIC_ENABLE_OFS) begin
        enable_q <= NUM_FAST_INTR'(apply_strb(DATA_WIDTH'(enable_q), reg_wdata_i, reg_wstrb_i));
      end
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    reg_error_o = 1'b0;
    case (ofs)
      FIC_PENDING_OFS: reg_rdata_o = DATA_WIDTH'(pending_q);
      FIC_ENABLE_OFS:  reg_rdata_o = DATA_WIDTH'(enable_q);
      default:         reg_error_o = 1'b1;
    endcase
  end

  assign fast_intr_o = pending_q & enable_q;

endmodule

`default_nettype wire

// ==== src/ao_peripheral_subsystem.sv ====
/* Always-on peripheral subsystem
   Bridges the core port onto the register bus and serves four slots */
`default_nettype none

module ao_peripheral_subsystem #(
  parameter logic [ao_periph_pkg::ADDR_WIDTH-1:0] AO_BASE_ADDR  = ao_periph_pkg::AO_BASE_DEFAULT,
  parameter int unsigned                         NUM_FAST_INTR = ao_periph_pkg::NUM_FAST_INTR_DEFAULT
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                req_i,
  input  logic                                we_i,
  input  logic [ao_periph_pkg::ADDR_WIDTH-1:0] addr_i,
  input  logic [ao_periph_pkg::DATA_WIDTH-1:0] wdata_i,
  input  logic [ao_periph_pkg::STRB_WIDTH-1:0] be_i,
  output logic                                gnt_o,
  output logic                                rvalid_o,
  output logic [ao_periph_pkg::DATA_WIDTH-1:0] rdata_o,
  output logic                                err_o,
  input  logic                                boot_select_i,
  output logic                                exit_valid_o,
  output logic [ao_periph_pkg::DATA_WIDTH-1:0] exit_value_o,
  output logic                                timer_0_intr_o,
  output logic                                timer_1_intr_o,
  input  logic [NUM_FAST_INTR-1:0]            fast_intr_i,
  output logic [NUM_FAST_INTR-1:0]            fast_intr_o,
  output logic                                ext_valid_o,
  output logic                                ext_write_o,
  output logic [ao_periph_pkg::ADDR_WIDTH-1:0] ext_addr_o,
  output logic [ao_periph_pkg::DATA_WIDTH-1:0] ext_wdata_o,
  output logic [ao_periph_pkg::STRB_WIDTH-1:0] ext_wstrb_o,
  input  logic                                ext_ready_i,
  input  logic [ao_periph_pkg::DATA_WIDTH-1:0] ext_rdata_i,
  input  logic                                ext_error_i
);
  import ao_periph_pkg::*;

  logic                                 reg_valid;
  logic                                 reg_write;
  logic [ADDR_WIDTH-1:0]                reg_addr;
  logic [DATA_WIDTH-1:0]                reg_wdata;
  logic [STRB_WIDTH-1:0]                reg_wstrb;
  logic                                 reg_ready;
  logic [DATA_WIDTH-1:0]                reg_rdata;
  logic                                 reg_error;
  logic [NUM_SLOTS-1:0]                 slot_valid;
  logic [NUM_SLOTS-1:0]                 slot_ready;
  logic [NUM_SLOTS-1:0][DATA_WIDTH-1:0] slot_rdata;
  logic [NUM_SLOTS-1:0]                 slot_error;

  periph_to_reg periph_to_reg_i (
    .clk_i, .rst_n_i, .req_i, .we_i, .addr_i, .wdata_i, .be_i,
    .gnt_o, .rvalid_o, .rdata_o, .err_o,
    .reg_valid_o(reg_valid), .reg_write_o(reg_write), .reg_addr_o(reg_addr),
    .reg_wdata_o(reg_wdata), .reg_wstrb_o(reg_wstrb),
    .reg_ready_i(reg_ready), .reg_rdata_i(reg_rdata), .reg_error_i(reg_error)
  );

  reg_demux #(.AO_BASE_ADDR(AO_BASE_ADDR)) reg_demux_i (
    .reg_valid_i(reg_valid), .reg_addr_i(reg_addr),
    .reg_ready_o(reg_ready), .reg_rdata_o(reg_rdata), .reg_error_o(reg_error),
    .slot_valid_o(slot_valid), .slot_ready_i(slot_ready),
    .slot_rdata_i(slot_rdata), .slot_error_i(slot_error)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i, .rst_n_i,
    .reg_valid_i(slot_valid[SOC_CTRL_IDX]), .reg_write_i(reg_write), .reg_addr_i(reg_addr),
    .reg_wdata_i(reg_wdata), .reg_wstrb_i(reg_wstrb),
    .reg_ready_o(slot_ready[SOC_CTRL_IDX]), .reg_rdata_o(slot_rdata[SOC_CTRL_IDX]),
    .reg_error_o(slot_error[SOC_CTRL_IDX]),
    .boot_select_i, .exit_valid_o, .exit_value_o
  );

  ao_timer ao_timer_i (
    .clk_i, .rst_n_i,
    .reg_valid_i(slot_valid[TIMER_IDX]), .reg_write_i(reg_write), .reg_addr_i(reg_addr),
    .reg_wdata_i(reg_wdata), .reg_wstrb_i(reg_wstrb),
    .reg_ready_o(slot_ready[TIMER_IDX]), .reg_rdata_o(slot_rdata[TIMER_IDX]),
    .reg_error_o(slot_error[TIMER_IDX]),
    .timer_0_intr_o, .timer_1_intr_o
  );

  fast_intr_ctrl #(.NUM_FAST_INTR(NUM_FAST_INTR)) fast_intr_ctrl_i (
    .clk_i, .rst_n_i,
    .reg_valid_i(slot_valid[FAST_INTR_IDX]), .reg_write_i(reg_write), .reg_addr_i(reg_addr),
    .reg_wdata_i(reg_wdata), .reg_wstrb_i(reg_wstrb),
    .reg_ready_o(slot_ready[FAST_INTR_IDX]), .reg_rdata_o(slot_rdata[FAST_INTR_IDX]),
    .reg_error_o(slot_error[FAST_INTR_IDX]),
    .fast_intr_i, .fast_intr_o
  );

  // External slot goes straight out to the pins
  assign ext_valid_o                = slot_valid[EXT_PERIPH_IDX];
  assign ext_write_o                = reg_write;
  assign ext_addr_o                 = reg_addr;
  assign ext_wdata_o                = reg_wdata;
  assign ext_wstrb_o                = reg_wstrb;
  assign slot_ready[EXT_PERIPH_IDX] = ext_ready_i;
  assign slot_rdata[EXT_PERIPH_IDX] = ext_rdata_i;
  assign slot_error[EXT_PERIPH_IDX] = ext_error_i;

endmodule

`default_nettype wire

// ==== bench/ao_peripheral_subsystem_tb.sv ====
/* Testbench for the always-on peripheral subsystem
   Table-driven bus accesses against the internal slots and an external slave model */
`default_nettype none

module ao_peripheral_subsystem_tb;
  import ao_periph_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 4;
  localparam int STALL_MAX    = 6;
  localparam int MAX_STEPS    = 48;
  localparam int NFI          = NUM_FAST_INTR_DEFAULT;

  localparam logic [31:0] SOC_BASE = 32'h2000_0000;
  localparam logic [31:0] TMR_BASE = 32'h2000_1000;
  localparam logic [31:0] FIC_BASE = 32'h2000_2000;
  localparam logic [31:0] EXT_BASE = 32'h2000_3000;

  // Output pin compared after a response
  localparam int PIN_NONE       = 0;
  localparam int PIN_EXIT_VALUE = 1;
  localparam int PIN_EXIT_VALID = 2;
  localparam int PIN_TIMER      = 3;
  localparam int PIN_FAST       = 4;

  logic                  clk_i = 1'b0;
  logic                  rst_n_i = 1'b0;
  logic                  req_i = 1'b0;
  logic                  we_i = 1'b0;
  logic [ADDR_WIDTH-1:0] addr_i = '0;
  logic [DATA_WIDTH-1:0] wdata_i = '0;
  logic [STRB_WIDTH-1:0] be_i = '0;
  logic                  gnt_o;
  logic                  rvalid_o;
  logic [DATA_WIDTH-1:0] rdata_o;
  logic                  err_o;
  logic                  boot_select_i = 1'b1;
  logic                  exit_valid_o;
  logic [DATA_WIDTH-1:0] exit_value_o;
  logic                  timer_0_intr_o;
  logic                  timer_1_intr_o;
  logic [NFI-1:0]        fast_intr_i = '0;
  logic [NFI-1:0]        fast_intr_o;
  logic                  ext_valid_o;
  logic                  ext_write_o;
  logic [ADDR_WIDTH-1:0] ext_addr_o;
  logic [DATA_WIDTH-1:0] ext_wdata_o;
  logic [STRB_WIDTH-1:0] ext_wstrb_o;
  logic                  ext_ready_i = 1'b0;
  logic [DATA_WIDTH-1:0] ext_rdata_i = '0;
  logic                  ext_error_i = 1'b0;

  string       s_name [MAX_STEPS];
  bit          s_wr [MAX_STEPS];
  logic [31:0] s_addr [MAX_STEPS];
  logic [31:0] s_wdata [MAX_STEPS];
  logic [3:0]  s_strb [MAX_STEPS];
  logic [31:0] s_rdata [MAX_STEPS];
  bit          s_err [MAX_STEPS];
  int          s_stall [MAX_STEPS];
  logic [NFI-1:0] s_pulse [MAX_STEPS];
  int          s_pin [MAX_STEPS];
  logic [31:0] s_pin_exp [MAX_STEPS];
  bit          s_ge [MAX_STEPS];
  bit          s_boot [MAX_STEPS];

  int          num_steps = 0;
  bit          table_done = 1'b0;
  int          checks = 0;
  int          errors = 0;
  int          cur_stall = 1;
  int          wait_cnt = 0;
  logic [31:0] ext_mem [16];

  ao_peripheral_subsystem #(
    .AO_BASE_ADDR(AO_BASE_DEFAULT),
    .NUM_FAST_INTR(NFI)
  ) dut (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic logic [31:0] ext_fill(input int idx);
    return 32'hE500_0000 | (32'(idx) << 12) | (32'(idx) << 2);
  endfunction

  // External slave, ready held low for the stall count of the current step
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      ext_ready_i <= 1'b0;
      wait_cnt    <= 0;
      for (int i = 0; i < 16; i++) ext_mem[i] <= ext_fill(i);
    end else if (ext_valid_o && ext_ready_i) begin
      ext_ready_i <= 1'b0;
      wait_cnt    <= 0;
      if (ext_write_o) begin
        for (int b = 0; b < 4; b++) begin
          if (ext_wstrb_o[b]) ext_mem[ext_addr_o[5:2]][8*b +: 8] <= ext_wdata_o[8*b +: 8];
        end
      end
    end else if (ext_valid_o) begin
      if (wait_cnt + 1 >= cur_stall) begin
        ext_ready_i <= 1'b1;
        ext_rdata_i <= ext_mem[ext_addr_o[5:2]];
      end
      wait_cnt <= wait_cnt + 1;
    end
  end

  task automatic add_step(input string name, input bit wr, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [3:0] strb,
                          input logic [31:0] rdata, input bit err, input int stall,
                          input logic [NFI-1:0] pulse, input int pin, input logic [31:0] pin_exp);
    s_name[num_steps]    = name;
    s_wr[num_steps]      = wr;
    s_addr[num_steps]    = addr;
    s_wdata[num_steps]   = wdata;
    s_strb[num_steps]    = strb;
    s_rdata[num_steps]   = rdata;
    s_err[num_steps]     = err;
    s_stall[num_steps]   = stall;
    s_pulse[num_steps]   = pulse;
    s_pin[num_steps]     = pin;
    s_pin_exp[num_steps] = pin_exp;
    s_ge[num_steps]      = 1'b0;
    s_boot[num_steps]    = 1'b1;
    num_steps++;
  endtask

  task automatic build_table();
    logic [31:0] ext_data [4];
    for (int k = 0; k < 4; k++) ext_data[k] = $urandom();
    add_step("soc_exit_value_full", 1, SOC_BASE + 4, 32'h1122_3344, 4'hF, 0, 0, 0, '0,
             PIN_EXIT_VALUE, 32'h1122_3344);
    add_step("soc_exit_value_partial", 1, SOC_BASE + 4, 32'hAABB_CCDD, 4'b0101, 0, 0, 0, '0,
             PIN_EXIT_VALUE, 32'h11BB_33DD);
    add_step("soc_exit_value_read", 0, SOC_BASE + 4, 0, 4'hF, 32'h11BB_33DD, 0, 0, '0, PIN_NONE, 0);
    add_step("soc_exit_valid_write", 1, SOC_BASE, 1, 4'hF, 0, 0, 0, '0, PIN_EXIT_VALID, 1);
    add_step("soc_exit_valid_read", 0, SOC_BASE, 0, 4'hF, 1, 0, 0, '0, PIN_NONE, 0);
    add_step("soc_boot_sel_read", 0, SOC_BASE + 8, 0, 4'hF, 1, 0, 0, '0, PIN_NONE, 0);
    add_step("soc_bad_offset", 0, SOC_BASE + 12, 0, 4'hF, 0, 1, 0, '0, PIN_NONE, 0);
    // Boot select drops a step early to get through the synchronizer
    s_boot[num_steps-1] = 1'b0;
    add_step("soc_boot_sel_low", 0, SOC_BASE + 8, 0, 4'hF, 0, 0, 0, '0, PIN_NONE, 0);
    s_boot[num_steps-1] = 1'b0;
    add_step("tmr_prescale_write", 1, TMR_BASE, 3, 4'hF, 0, 0, 0, '0, PIN_NONE, 0);
    add_step("tmr_prescale_read", 0, TMR_BASE, 0, 4'hF, 3, 0, 0, '0, PIN_NONE, 0);
    add_step("tmr_mtime_write", 1, TMR_BASE + 8, 100, 4'hF, 0, 0, 0, '0, PIN_NONE, 0);
    add_step("tmr_cmp0_write", 1, TMR_BASE + 16, 50, 4'hF, 0, 0, 0, '0, PIN_NONE, 0);
    add_step("tmr_ctrl_enable", 1, TMR_BASE + 4, 3, 4'hF, 0, 0, 0, '0, PIN_NONE, 0);
    // Counter runs, so only a lower bound holds
    add_step("tmr_mtime_read", 0, TMR_BASE + 8, 0, 4'hF, 100, 0, 0, '0, PIN_TIMER, 1);
    s_ge[num_steps-1] = 1'b1;
    add_step("tmr_ctrl_mask", 1, TMR_BASE + 4, 1, 4'hF, 0, 0, 0, '0, PIN_TIMER, 1);
    add_step("tmr_intr_clear", 1, TMR_BASE + 24, 1, 4'hF, 0, 0, 0, '0, PIN_TIMER, 0);
    add_step("tmr_intr_read", 0, TMR_BASE + 24, 0, 4'hF, 0, 0, 0, '0, PIN_NONE, 0);
    add_step("fic_pulse_pending", 0, FIC_BASE, 0, 4'hF, 8, 0, 0, NFI'(8), PIN_FAST, 0);
    add_step("fic_enable_write", 1, FIC_BASE + 4, 8, 4'hF, 0, 0, 0, '0, PIN_FAST, 8);
    add_step("fic_enable_read", 0, FIC_BASE + 4, 0, 4'hF, 8, 0, 0, '0, PIN_NONE, 0);
    add_step("fic_pending_clear", 1, FIC_BASE, 8, 4'hF, 0, 0, 0, '0, PIN_FAST, 0);
    add_step("fic_pending_read", 0, FIC_BASE, 0, 4'hF, 0, 0, 0, '0, PIN_NONE, 0);
    for (int k = 0; k < 4; k++) begin
      add_step($sformatf("ext_write_%0d", k), 1, EXT_BASE | (32'(k) << 2), ext_data[k], 4'hF,
               0, 0, $urandom_range(STALL_MAX, 1), '0, PIN_NONE, 0);
    end
    for (int k = 0; k < 4; k++) begin
      add_step($sformatf("ext_read_%0d", k), 0, EXT_BASE | (32'(k) << 2), 0, 4'hF,
               ext_data[k], 0, $urandom_range(STALL_MAX, 1), '0, PIN_NONE, 0);
    end
    add_step("ext_read_fill", 0, EXT_BASE + 60, 0, 4'hF, ext_fill(15), 0,
             $urandom_range(STALL_MAX, 1), '0, PIN_NONE, 0);
    add_step("out_of_window_read", 0, 32'h3000_0000, 0, 4'hF, 0, 1, 0, '0, PIN_NONE, 0);
    add_step("out_of_window_write", 1, 32'h2000_4004, 32'hDEAD_BEEF, 4'hF, 0, 1, 0, '0,
             PIN_EXIT_VALUE, 32'h11BB_33DD);
    add_step("soc_exit_value_kept", 0, SOC_BASE + 4, 0, 4'hF, 32'h11BB_33DD, 0, 0, '0,
             PIN_NONE, 0);
  endtask

  function automatic logic [31:0] pin_value(input int kind);
    case (kind)
      PIN_EXIT_VALUE: return exit_value_o;
      PIN_EXIT_VALID: return 32'(exit_valid_o);
      PIN_TIMER:      return {30'b0, timer_1_intr_o, timer_0_intr_o};
      PIN_FAST:       return 32'(fast_intr_o);
      default:        return '0;
    endcase
  endfunction

  task automatic check_value(input string name, input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("Mismatch %s %s: expected 0x%08h, actual 0x%08h", name, what, exp, act);
    end
  endtask

  task automatic check_reset_state();
    check_value("reset", "gnt_o", 32'd1, 32'(gnt_o));
    check_value("reset", "rvalid_o", 32'd0, 32'(rvalid_o));
    check_value("reset", "exit_valid_o", 32'd0, 32'(exit_valid_o));
    check_value("reset", "timer intr", 32'd0, pin_value(PIN_TIMER));
    check_value("reset", "fast_intr_o", 32'd0, pin_value(PIN_FAST));
    check_value("reset", "ext_valid_o", 32'd0, 32'(ext_valid_o));
  endtask

  task automatic run_step(input int i);
    int cycles;
    bit to_ext;
    to_ext = (s_addr[i] >= EXT_BASE) && (s_addr[i] < EXT_BASE + 32'h1000);
    if (s_pulse[i] != '0) begin
      @(posedge clk_i);
      fast_intr_i <= s_pulse[i];
      @(posedge clk_i);
      fast_intr_i <= '0;
    end
    cur_stall = s_stall[i];
    @(posedge clk_i);
    req_i         <= 1'b1;
    we_i          <= s_wr[i];
    addr_i        <= s_addr[i];
    wdata_i       <= s_wdata[i];
    be_i          <= s_strb[i];
    boot_select_i <= s_boot[i];
    @(negedge clk_i);
    check_value(s_name[i], "gnt_o", 32'd1, 32'(gnt_o));
    @(posedge clk_i);
    req_i <= 1'b0;
    cycles = 0;
    // Grant stays low until the response cycle
    do begin
      @(negedge clk_i);
      cycles++;
      if (!rvalid_o) check_value(s_name[i], "gnt_o while held", 32'd0, 32'(gnt_o));
      // Only the external slot reaches the pins, and only while the request is held
      check_value(s_name[i], "ext_valid_o", 32'(to_ext && !rvalid_o), 32'(ext_valid_o));
      if (ext_valid_o) begin
        check_value(s_name[i], "ext_write_o", 32'(s_wr[i]), 32'(ext_write_o));
        check_value(s_name[i], "ext_addr_o", s_addr[i], ext_addr_o);
        if (s_wr[i]) begin
          check_value(s_name[i], "ext_wdata_o", s_wdata[i], ext_wdata_o);
          check_value(s_name[i], "ext_wstrb_o", 32'(s_strb[i]), 32'(ext_wstrb_o));
        end
      end
    end while (!rvalid_o && cycles < STALL_MAX + 8);
    checks++;
    assert (rvalid_o) else begin
      errors++;
      $display("Step %s got no response from the DUT", s_name[i]);
    end
    check_value(s_name[i], "latency", 32'(s_stall[i] + 2), 32'(cycles));
    check_value(s_name[i], "err_o", 32'(s_err[i]), 32'(err_o));
    if (s_ge[i]) begin
      checks++;
      assert (rdata_o >= s_rdata[i]) else begin
        errors++;
        $display("Mismatch %s rdata_o: expected at least 0x%08h, actual 0x%08h",
                 s_name[i], s_rdata[i], rdata_o);
      end
    end else begin
      check_value(s_name[i], "rdata_o", s_rdata[i], rdata_o);
    end
    if (s_pin[i] != PIN_NONE) check_value(s_name[i], "pin", s_pin_exp[i], pin_value(s_pin[i]));
  endtask

  initial begin : watchdog
    longint limit;
    wait (table_done);
    limit = longint'(num_steps * (STALL_MAX + 10) + RESET_CYCLES + 4) * CLK_PERIOD;
    #(limit);
    $display("Timeout: the run did not finish within %0d time units", limit);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin : main
    void'($urandom(65683));
    build_table();
    table_done = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_reset_state();
    for (int i = 0; i < num_steps; i++) run_step(i);
    $display("Summary: %0d steps, %0d checks, %0d errors", num_steps, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== ao_peripheral_subsystem.f ====
src/ao_periph_pkg.sv
src/periph_to_reg.sv
src/reg_demux.sv
src/soc_ctrl.sv
src/ao_timer.sv
src/fast_intr_ctrl.sv
src/ao_peripheral_subsystem.sv
bench/ao_peripheral_subsystem_tb.sv

// ==== Makefile ====
# Verilator build and run for the always-on peripheral subsystem

TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = ao_peripheral_subsystem_tb
FILELIST = ao_peripheral_subsystem.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
